// ==== source/video_config.svh ====
/*
 * build constants for the mono high-res video path
 * 640x400 active at 72 Hz plus the centred OSD window
 * include wherever frame geometry or reset values are needed
 */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// read prefetch ahead of display, in pixel clocks
`define VIDEO_H_PRE 16

// active area
`define VIDEO_H_ACT 640
`define VIDEO_V_ACT 400

// horizontal blanking, total 832
`define VIDEO_H_FP 24
`define VIDEO_H_SYNC 40
`define VIDEO_H_BP 128

// vertical blanking, total 531 lines
`define VIDEO_V_FP 55
`define VIDEO_V_SYNC 3
`define VIDEO_V_BP 73

// screen base after reset, word address
`define VIDEO_BASE_RESET 23'h008000

// osd window size in pixels
// height counts doubled lines
`define OSD_WIDTH 256
`define OSD_HEIGHT 128

`endif

// ==== source/video_pkg.sv ====
/*
 * vector types shared by the video controller blocks
 * import into a module body, use scoped names in port lists
 */
package video_pkg;

	// horizontal or vertical position
	typedef logic [9:0] pix_cnt_t;

	// video word address into st ram
	typedef logic [22:0] vid_addr_t;

	// memory word, also cpu register data
	typedef logic [15:0] vid_word_t;

	// cpu register index
	typedef logic [5:0] reg_addr_t;

	// phase within the 16 clock bus cycle
	typedef logic [3:0] bus_phase_t;

	// one colour channel to the dac
	typedef logic [5:0] rgb6_t;

	// byte address into the osd buffer
	typedef logic [10:0] osd_addr_t;

endpackage

// ==== source/video_timing.sv ====
/*
 * frame counters for the 72 Hz mono mode
 * gives raw positive syncs plus line and frame markers,
 * positions count from the start of the read prefetch
 */
`timescale 1ns/100ps
`include "video_config.svh"

module video_timing (
	input  logic                clk,
	input  logic                ss,
	output video_pkg::pix_cnt_t hcnt,
	output video_pkg::pix_cnt_t vcnt,
	output logic                hsync_raw,
	output logic                vsync_raw,
	output logic                line_end,
	output logic                frame_end
);
	import video_pkg::*;

	// line and frame totals
	localparam pix_cnt_t H_TOTAL =
		pix_cnt_t'(`VIDEO_H_ACT + `VIDEO_H_FP + `VIDEO_H_SYNC + `VIDEO_H_BP);
	localparam pix_cnt_t V_TOTAL =
		pix_cnt_t'(`VIDEO_V_ACT + `VIDEO_V_FP + `VIDEO_V_SYNC + `VIDEO_V_BP);

	// hsync is shifted by the prefetch like the display window
	localparam pix_cnt_t H_SYNC_ON = pix_cnt_t'(`VIDEO_H_PRE + `VIDEO_H_ACT + `VIDEO_H_FP);
	localparam pix_cnt_t H_SYNC_OFF = H_SYNC_ON + pix_cnt_t'(`VIDEO_H_SYNC);
	localparam pix_cnt_t V_SYNC_ON = pix_cnt_t'(`VIDEO_V_ACT + `VIDEO_V_FP);
	localparam pix_cnt_t V_SYNC_OFF = V_SYNC_ON + pix_cnt_t'(`VIDEO_V_SYNC);

	// counters restart with the bus sequencer on reset
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (hcnt != H_TOTAL - pix_cnt_t'(1)) begin
				hcnt <= hcnt + pix_cnt_t'(1);
			end else begin
				hcnt <= '0;
				// next line at the horizontal wrap
				if (vcnt != V_TOTAL - pix_cnt_t'(1))
					vcnt <= vcnt + pix_cnt_t'(1);
				else
					vcnt <= '0;
			end
		end
	end

	// sync windows, active high here
	assign hsync_raw = (hcnt >= H_SYNC_ON) && (hcnt < H_SYNC_OFF);
	assign vsync_raw = (vcnt >= V_SYNC_ON) && (vcnt < V_SYNC_OFF);

	// markers well clear of the visible area
	// the fetch counter rewinds where both meet
	assign line_end = (hcnt == H_SYNC_ON);
	assign frame_end = (vcnt == V_SYNC_ON);

	// counter must wrap at the line total
	a_hcnt_range: assert property (@(posedge clk) disable iff (ss)
		hcnt <= H_TOTAL - pix_cnt_t'(1))
		else $error("hcnt beyond line total: %0d", hcnt);

endmodule

// ==== source/video_regs.sv ====
/*
 * cpu visible registers of the shifter
 * screen base, live fetch address read-back and palette entry 0,
 * written on clk with active-low byte strobes, read combinationally
 */
`timescale 1ns/100ps
`include "video_config.svh"

module video_regs (
	input  logic                 clk,
	input  logic                 ss,
	input  logic                 reg_sel,
	input  logic                 reg_uds,
	input  logic                 reg_lds,
	input  logic                 reg_rw,
	input  video_pkg::reg_addr_t reg_addr,
	input  video_pkg::vid_word_t reg_din,
	input  video_pkg::vid_addr_t vaddr,
	output video_pkg::vid_word_t reg_dout,
	output video_pkg::vid_addr_t base_addr,
	output logic                 invert
);
	import video_pkg::*;

	// register map
	localparam reg_addr_t REG_BASE_HI = 6'h00;
	localparam reg_addr_t REG_BASE_MID = 6'h01;
	localparam reg_addr_t REG_VADDR_HI = 6'h02;
	localparam reg_addr_t REG_VADDR_MID = 6'h03;
	localparam reg_addr_t REG_VADDR_LO = 6'h04;
	localparam reg_addr_t REG_PAL0 = 6'h20;

	localparam vid_addr_t BASE_RESET = `VIDEO_BASE_RESET;

	// base is 128 word aligned, only 16 bits stored
	logic [7:0] base_hi;
	logic [7:0] base_mid;
	// palette 0, 3 bits per gun
	logic [2:0] pal_r;
	logic [2:0] pal_g;
	logic [2:0] pal_b;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_hi <= BASE_RESET[22:15];
			base_mid <= BASE_RESET[14:7];
			pal_r <= 3'd0;
			pal_g <= 3'd0;
			// blue all set, mono comes up inverted
			pal_b <= 3'd7;
		end else if (reg_sel && !reg_rw) begin
			// base bytes sit on the low lane
			if (reg_addr == REG_BASE_HI && !reg_lds)
				base_hi <= reg_din[7:0];
			if (reg_addr == REG_BASE_MID && !reg_lds)
				base_mid <= reg_din[7:0];
			if (reg_addr == REG_PAL0) begin
				// red on the upper lane, green and blue on the lower
				if (!reg_uds)
					pal_r <= reg_din[10:8];
				if (!reg_lds) begin
					pal_g <= reg_din[6:4];
					pal_b <= reg_din[2:0];
				end
			end
		end
	end

	assign base_addr = {base_hi, base_mid, 7'd0};
	assign invert = pal_b[0];

	// read mux, idle bus reads zero
	always_comb begin
		reg_dout = '0;
		if (reg_sel && reg_rw) begin
			case (reg_addr)
				REG_BASE_HI:   if (!reg_lds) reg_dout = {8'h00, base_hi};
				REG_BASE_MID:  if (!reg_lds) reg_dout = {8'h00, base_mid};
				// live counter, so software can see the beam
				REG_VADDR_HI:  if (!reg_lds) reg_dout = {8'h00, vaddr[22:15]};
				REG_VADDR_MID: if (!reg_lds) reg_dout = {8'h00, vaddr[14:7]};
				REG_VADDR_LO:  if (!reg_lds) reg_dout = {8'h00, vaddr[6:0], 1'b0};
				REG_PAL0:      reg_dout = {5'd0, pal_r, 1'b0, pal_g, 1'b0, pal_b};
				default:       reg_dout = '0;
			endcase
		end
	end

endmodule

// ==== source/video_fetch.sv ====
/*
 * screen memory fetch and mono pixel serialiser
 * reads one word per 16 clock bus cycle, 16 clocks ahead of display,
 * memory has to answer in bus phase 3
 */
`timescale 1ns/100ps
`include "video_config.svh"

module video_fetch (
	input  logic                  clk,
	input  logic                  ss,
	input  video_pkg::bus_phase_t bus_cycle,
	input  video_pkg::pix_cnt_t   hcnt,
	input  video_pkg::pix_cnt_t   vcnt,
	input  logic                  line_end,
	input  logic                  frame_end,
	input  video_pkg::vid_addr_t  base_addr,
	input  video_pkg::vid_word_t  data,
	output video_pkg::vid_addr_t  vaddr,
	output logic                  read,
	output logic                  shift_msb
);
	import video_pkg::*;

	localparam pix_cnt_t H_ACT = `VIDEO_H_ACT;
	localparam pix_cnt_t V_ACT = `VIDEO_V_ACT;
	// memory data is valid in this phase
	localparam bus_phase_t FETCH_PHASE = 4'd3;

	logic fetch;
	logic rewind;
	vid_word_t data_latch;
	vid_word_t shifter;

	// video owns bus phases 0..3 during the active area
	assign read = (bus_cycle[3:2] == 2'b00) && (hcnt < H_ACT) && (vcnt < V_ACT);
	assign fetch = read && (bus_cycle == FETCH_PHASE);
	// back to the base once per frame, in the blank
	assign rewind = !read && line_end && frame_end;

	// reset value matches the base register reset
	always_ff @(posedge clk or posedge ss) begin
		if (ss)
			vaddr <= `VIDEO_BASE_RESET;
		else if (fetch)
			vaddr <= vaddr + vid_addr_t'(1);
		else if (rewind)
			vaddr <= base_addr;
	end

	always_ff @(posedge clk) begin
		if (fetch)
			data_latch <= data;
		// reload on the last pixel of each 16 pixel group
		if (hcnt[3:0] == 4'hf)
			shifter <= data_latch;
		else
			shifter <= {shifter[14:0], 1'b0};
	end

	// msb first, leftmost pixel
	assign shift_msb = shifter[15];

	// address moves only by stepping or by the frame rewind
	a_vaddr_step: assert property (@(posedge clk) disable iff (ss)
		!$stable(vaddr) |-> $past(fetch || rewind))
		else $error("vaddr changed outside fetch or rewind");

endmodule

// ==== source/osd_overlay.sv ====
/*
 * on-screen display overlay
 * commands and bitmap bytes arrive over spi on sck, spi_sel high idles;
 * the 2 KB buffer is read on clk to colour the centred 256x128 window
 */
`timescale 1ns/100ps
`include "video_config.svh"

module osd_overlay (
	input  logic                clk,
	input  logic                sck,
	input  logic                spi_sel,
	input  logic                sdi,
	input  video_pkg::pix_cnt_t hcnt,
	input  video_pkg::pix_cnt_t vcnt,
	output logic                osd_oe,
	output logic                osd_pixel
);
	import video_pkg::*;

	// window centred in the active area
	localparam pix_cnt_t OSD_W = `OSD_WIDTH;
	localparam pix_cnt_t OSD_H = `OSD_HEIGHT;
	localparam pix_cnt_t OSD_X = (`VIDEO_H_ACT - `OSD_WIDTH) / 2;
	localparam pix_cnt_t OSD_Y = (`VIDEO_V_ACT - `OSD_HEIGHT) / 2;

	// spi side
	logic [6:0] sbuf;
	logic [4:0] cmd;
	logic [3:0] cnt;
	logic write_byte;
	osd_addr_t wr_ptr;
	// stays off until the io controller turns it on
	logic osd_enable = 1'b0;

	// 8 rows of 256 bytes, each byte is 8 doubled lines
	logic [7:0] osd_buffer [0:2047];

	// video side
	pix_cnt_t h_off;
	pix_cnt_t v_off;
	osd_addr_t rd_addr;
	logic [7:0] osd_byte;

	// write command, payload byte complete
	assign write_byte = (cmd == 5'b00100) && (cnt == 4'd15);

	// bit count 0..7 is the command, then 8..15 repeats per data byte
	always_ff @(posedge sck or posedge spi_sel) begin
		if (spi_sel) begin
			cnt <= '0;
			wr_ptr <= '0;
		end else begin
			if (cnt != 4'd15)
				cnt <= cnt + 4'd1;
			else
				cnt <= 4'd8;
			// low 3 command bits pick the row
			if (cnt == 4'd7)
				wr_ptr <= {sbuf[1:0], sdi, 8'h00};
			else if (write_byte)
				wr_ptr <= wr_ptr + osd_addr_t'(1);
		end
	end

	always_ff @(posedge sck) begin
		sbuf <= {sbuf[5:0], sdi};
		if (cnt == 4'd7) begin
			cmd <= sbuf[6:2];
			// 0x40 family, bit 0 is the enable
			if (sbuf[6:3] == 4'b0100)
				osd_enable <= sdi;
		end
		if (write_byte)
			osd_buffer[wr_ptr] <= {sbuf, sdi};
	end

	// enable only changes between frames, used directly on clk
	assign osd_oe = osd_enable &&
		(hcnt >= OSD_X) && (hcnt < OSD_X + OSD_W) &&
		(vcnt >= OSD_Y) && (vcnt < OSD_Y + OSD_H);

	// one column ahead to cover the buffer read latency
	assign h_off = hcnt - OSD_X + pix_cnt_t'(1);
	assign v_off = vcnt - OSD_Y;
	assign rd_addr = {v_off[6:4], h_off[7:0]};

	always_ff @(posedge clk) begin
		osd_byte <= osd_buffer[rd_addr];
	end

	// lines doubled, so bit index is the line pair
	assign osd_pixel = osd_oe && osd_byte[v_off[3:1]];

	a_pixel_in_window: assert property (@(posedge clk) !osd_oe |-> !osd_pixel)
		else $error("osd pixel set outside the window");

endmodule

// ==== source/video.sv ====
/*
 * st mono video controller top
 * ties timing, registers, fetch and osd together and drives
 * negative syncs and 6 bit rgb towards the dac
 */
`timescale 1ns/100ps
`include "video_config.svh"

module video (
	input  logic                  clk,
	input  logic                  ss,
	input  video_pkg::bus_phase_t bus_cycle,
	input  video_pkg::vid_word_t  data,
	output logic                  read,
	output video_pkg::vid_addr_t  vaddr,
	input  logic                  reg_sel,
	input  video_pkg::reg_addr_t  reg_addr,
	input  video_pkg::vid_word_t  reg_din,
	input  logic                  reg_uds,
	input  logic                  reg_lds,
	input  logic                  reg_rw,
	output video_pkg::vid_word_t  reg_dout,
	input  logic                  sck,
	input  logic                  spi_sel,
	input  logic                  sdi,
	output logic                  hs,
	output logic                  vs,
	output video_pkg::rgb6_t      video_r,
	output video_pkg::rgb6_t      video_g,
	output video_pkg::rgb6_t      video_b
);
	import video_pkg::*;

	// display window trails the fetch by the prefetch
	localparam pix_cnt_t DE_H_START = `VIDEO_H_PRE;
	localparam pix_cnt_t DE_H_END = `VIDEO_H_PRE + `VIDEO_H_ACT;
	localparam pix_cnt_t DE_V_END = `VIDEO_V_ACT;

	pix_cnt_t hcnt;
	pix_cnt_t vcnt;
	logic hsync_raw;
	logic vsync_raw;
	logic line_end;
	logic frame_end;
	vid_addr_t base_addr;
	logic invert;
	logic shift_msb;
	logic osd_oe;
	logic osd_pixel;
	logic de;
	logic mono;

	video_timing timing_inst (
		.clk(clk), .ss(ss), .hcnt(hcnt), .vcnt(vcnt),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
		.line_end(line_end), .frame_end(frame_end)
	);

	video_regs regs_inst (
		.clk(clk), .ss(ss), .reg_sel(reg_sel), .reg_uds(reg_uds),
		.reg_lds(reg_lds), .reg_rw(reg_rw), .reg_addr(reg_addr),
		.reg_din(reg_din), .vaddr(vaddr), .reg_dout(reg_dout),
		.base_addr(base_addr), .invert(invert)
	);

	video_fetch fetch_inst (
		.clk(clk), .ss(ss), .bus_cycle(bus_cycle), .hcnt(hcnt), .vcnt(vcnt),
		.line_end(line_end), .frame_end(frame_end), .base_addr(base_addr),
		.data(data), .vaddr(vaddr), .read(read), .shift_msb(shift_msb)
	);

	osd_overlay osd_inst (
		.clk(clk), .sck(sck), .spi_sel(spi_sel), .sdi(sdi),
		.hcnt(hcnt), .vcnt(vcnt), .osd_oe(osd_oe), .osd_pixel(osd_pixel)
	);

	assign de = (hcnt >= DE_H_START) && (hcnt < DE_H_END) && (vcnt < DE_V_END);

	// mono monitor wants negative syncs
	assign hs = ~hsync_raw;
	assign vs = ~vsync_raw;

	// palette blue bit 0 swaps black and white
	assign mono = de && (shift_msb ^ invert);

	// osd takes the upper bits, screen shows dimmed below it
	assign video_r = osd_oe ? {{3{osd_pixel}}, {3{mono}}} : {6{mono}};
	// green bit 3 tints the whole osd window
	assign video_g = osd_oe ? {{2{osd_pixel}}, 1'b1, {3{mono}}} : {6{mono}};
	assign video_b = osd_oe ? {{3{osd_pixel}}, {3{mono}}} : {6{mono}};

endmodule

// ==== tb/video_tb.sv ====
/*
 * directed testbench for the mono video controller
 * drives the cpu register bus, a constant memory word and the osd spi,
 * measures the syncs and counts pixels over whole frames
 */
`timescale 1ns/100ps
`include "video_config.svh"

module video_tb;
	import video_pkg::*;

	localparam int H_TOTAL = `VIDEO_H_ACT + `VIDEO_H_FP + `VIDEO_H_SYNC + `VIDEO_H_BP;
	localparam int V_TOTAL = `VIDEO_V_ACT + `VIDEO_V_FP + `VIDEO_V_SYNC + `VIDEO_V_BP;
	localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL;
	// first vsync line, the fetch counter rewinds on it
	localparam int VS_LINE = `VIDEO_V_ACT + `VIDEO_V_FP;
	localparam int WORDS_PER_LINE = `VIDEO_H_ACT / 16;
	// video owns 4 of the 16 bus phases per word
	localparam int READS_PER_FRAME = WORDS_PER_LINE * 4 * `VIDEO_V_ACT;
	localparam int HS_LIMIT = 2 * H_TOTAL;
	localparam int VS_LIMIT = FRAME_CLOCKS + 2 * H_TOTAL;

	logic clk;
	logic ss;
	bus_phase_t bus_cycle;
	vid_word_t data;
	logic read;
	vid_addr_t vaddr;
	logic reg_sel;
	reg_addr_t reg_addr;
	vid_word_t reg_din;
	logic reg_uds;
	logic reg_lds;
	logic reg_rw;
	vid_word_t reg_dout;
	logic sck;
	logic spi_sel;
	logic sdi;
	logic hs;
	logic vs;
	rgb6_t video_r;
	rgb6_t video_g;
	rgb6_t video_b;

	int checks = 0;
	int errors = 0;
	int test_checks;
	int test_errors;
	int cycles = 0;
	int read_clocks = 0;
	string cur_test = "";

	video video_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// bus sequencer phase, free running once out of reset
	always @(negedge clk) begin
		if (ss)
			bus_cycle <= '0;
		else
			bus_cycle <= bus_cycle + 4'd1;
	end

	// clock count, read on falling edges for sync timing
	always @(posedge clk)
		cycles <= cycles + 1;

	// memory read strobes as the dut sees them on the rising edge
	always @(posedge clk)
		if (read)
			read_clocks <= read_clocks + 1;

	task automatic compare_value(input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s: expected 0x%0h, actual 0x%0h", cur_test, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d errors", cur_test,
			checks - test_checks, errors - test_errors);
	endtask

	task automatic write_reg(input reg_addr_t addr, input vid_word_t value,
		input logic uds, input logic lds);
		@(negedge clk);
		reg_sel <= 1'b1;
		reg_rw <= 1'b0;
		reg_addr <= addr;
		reg_din <= value;
		reg_uds <= uds;
		reg_lds <= lds;
		@(negedge clk);
		reg_sel <= 1'b0;
		reg_rw <= 1'b1;
		reg_uds <= 1'b1;
		reg_lds <= 1'b1;
	endtask

	// read mux is combinational, sample a full cycle after driving
	task automatic read_reg(input reg_addr_t addr, output vid_word_t value);
		@(negedge clk);
		reg_sel <= 1'b1;
		reg_rw <= 1'b1;
		reg_addr <= addr;
		reg_uds <= 1'b0;
		reg_lds <= 1'b0;
		@(negedge clk);
		value = reg_dout;
		reg_sel <= 1'b0;
		reg_uds <= 1'b1;
		reg_lds <= 1'b1;
	endtask

	// live fetch address from the three read-back registers
	task automatic read_vaddr(output vid_addr_t addr);
		vid_word_t hi;
		vid_word_t mid;
		vid_word_t lo;
		read_reg(6'h02, hi);
		read_reg(6'h03, mid);
		read_reg(6'h04, lo);
		addr = {hi[7:0], mid[7:0], lo[7:1]};
	endtask

	function automatic logic sync_level(input bit on_vs);
		return on_vs ? vs : hs;
	endfunction

	task automatic wait_level(input bit on_vs, input logic level, input int limit);
		int n;
		n = 0;
		while (sync_level(on_vs) !== level && n <= limit) begin
			@(negedge clk);
			n++;
		end
		if (sync_level(on_vs) !== level) begin
			errors++;
			$display("timeout in %s: %s did not go %s within %0d clocks", cur_test,
				on_vs ? "vs" : "hs", level ? "high" : "low", limit);
		end
	endtask

	// returns on the first falling edge that sees the sync low
	task automatic wait_fall(input bit on_vs, input int limit);
		wait_level(on_vs, 1'b1, limit);
		wait_level(on_vs, 1'b0, limit);
	endtask

	// one full frame starting at a vsync edge, every position sampled once
	task automatic count_frame(output int r_full, output int b_full, output int r_osd,
		output int g_tint, output int reads);
		int read_start;
		r_full = 0;
		b_full = 0;
		r_osd = 0;
		g_tint = 0;
		wait_fall(1'b1, VS_LIMIT);
		read_start = read_clocks;
		repeat (FRAME_CLOCKS) begin
			if (video_r == 6'd63)
				r_full++;
			if (video_b == 6'd63)
				b_full++;
			// osd pixel set over black screen
			if (video_r == 6'b111000)
				r_osd++;
			if (video_g[3])
				g_tint++;
			@(negedge clk);
		end
		reads = read_clocks - read_start;
	endtask

	// spi mode 0, msb first, sck rises mid bit
	task automatic send_byte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			@(negedge clk);
			sck <= 1'b0;
			sdi <= value[i];
			@(negedge clk);
			sck <= 1'b1;
		end
	endtask

	task automatic select_osd();
		@(negedge clk);
		spi_sel <= 1'b0;
	endtask

	task automatic release_osd();
		@(negedge clk);
		sck <= 1'b0;
		@(negedge clk);
		spi_sel <= 1'b1;
	endtask

	task automatic reset_values();
		vid_word_t value;
		start_test("reset");
		@(negedge clk);
		compare_value(1, hs);
		compare_value(1, vs);
		// base 0x8000 is bit 15 set
		read_reg(6'h00, value);
		compare_value(16'h0001, value);
		read_reg(6'h01, value);
		compare_value(16'h0000, value);
		read_reg(6'h20, value);
		compare_value(16'h0007, value);
		end_test();
	endtask

	task automatic register_access();
		logic [7:0] hi;
		logic [7:0] mid;
		vid_word_t pal;
		vid_word_t pal_upper;
		vid_word_t value;
		start_test("registers");
		hi = 8'($urandom);
		mid = 8'($urandom);
		pal = vid_word_t'($urandom);
		write_reg(6'h00, {8'h00, hi}, 1'b0, 1'b0);
		write_reg(6'h01, {8'h00, mid}, 1'b0, 1'b0);
		write_reg(6'h20, pal, 1'b0, 1'b0);
		read_reg(6'h00, value);
		compare_value({8'h00, hi}, value);
		read_reg(6'h01, value);
		compare_value({8'h00, mid}, value);
		// 3 bits per gun, gaps read zero
		read_reg(6'h20, value);
		compare_value(pal & 16'h0777, value);
		// upper lane only, base sits on the lower one
		write_reg(6'h00, {~hi, ~hi}, 1'b0, 1'b1);
		read_reg(6'h00, value);
		compare_value({8'h00, hi}, value);
		// red follows, green and blue stay
		pal_upper = vid_word_t'($urandom);
		write_reg(6'h20, pal_upper, 1'b0, 1'b1);
		read_reg(6'h20, value);
		compare_value((pal_upper & 16'h0700) | (pal & 16'h0077), value);
		end_test();
	endtask

	task automatic sync_timing();
		int t0;
		int t1;
		int t2;
		start_test("sync");
		wait_fall(1'b0, HS_LIMIT);
		t0 = cycles;
		wait_level(1'b0, 1'b1, HS_LIMIT);
		t1 = cycles;
		wait_fall(1'b0, HS_LIMIT);
		t2 = cycles;
		compare_value(`VIDEO_H_SYNC, t1 - t0);
		compare_value(H_TOTAL, t2 - t0);
		// vsync spans whole lines
		wait_fall(1'b1, VS_LIMIT);
		t0 = cycles;
		wait_level(1'b1, 1'b1, VS_LIMIT);
		t1 = cycles;
		compare_value(`VIDEO_V_SYNC * H_TOTAL, t1 - t0);
		end_test();
	endtask

	task automatic address_stepping();
		logic [7:0] hi;
		logic [7:0] mid;
		vid_addr_t base;
		vid_addr_t addr;
		vid_addr_t expect_addr;
		int line;
		int done;
		start_test("address");
		hi = 8'($urandom);
		mid = 8'($urandom);
		base = {hi, mid, 7'd0};
		write_reg(6'h00, {8'h00, hi}, 1'b0, 1'b0);
		write_reg(6'h01, {8'h00, mid}, 1'b0, 1'b0);
		// rewind at the hsync of the first vsync line
		wait_fall(1'b1, VS_LIMIT);
		wait_fall(1'b0, HS_LIMIT);
		read_vaddr(addr);
		compare_value(base, addr);
		compare_value(base, vaddr);
		// walk through the blank into the first active lines
		for (int k = 1; k <= 80; k++) begin
			wait_fall(1'b0, HS_LIMIT);
			read_vaddr(addr);
			line = (VS_LINE + k) % V_TOTAL;
			done = (line < `VIDEO_V_ACT) ? line + 1 : 0;
			expect_addr = base + vid_addr_t'(done * WORDS_PER_LINE);
			compare_value(expect_addr, addr);
			// memory side address bus carries the same counter
			compare_value(expect_addr, vaddr);
		end
		end_test();
	endtask

	task automatic pixel_output();
		int r_full;
		int b_full;
		int r_osd;
		int g_tint;
		int reads;
		start_test("pixels");
		@(negedge clk);
		data <= 16'hffff;
		write_reg(6'h20, 16'h0000, 1'b0, 1'b0);
		// one frame so the fetch latch holds the new word
		wait_fall(1'b1, VS_LIMIT);
		count_frame(r_full, b_full, r_osd, g_tint, reads);
		compare_value(`VIDEO_H_ACT * `VIDEO_V_ACT, r_full);
		compare_value(`VIDEO_H_ACT * `VIDEO_V_ACT, b_full);
		compare_value(READS_PER_FRAME, reads);
		// blue bit 0 inverts, all white turns all black
		write_reg(6'h20, 16'h0001, 1'b0, 1'b0);
		count_frame(r_full, b_full, r_osd, g_tint, reads);
		compare_value(0, r_full);
		compare_value(0, b_full);
		end_test();
	endtask

	task automatic osd_window();
		int r_full;
		int b_full;
		int r_osd;
		int g_tint;
		int reads;
		start_test("osd");
		@(negedge clk);
		data <= 16'h0000;
		write_reg(6'h20, 16'h0000, 1'b0, 1'b0);
		select_osd();
		send_byte(8'h41);
		release_osd();
		// fill all 8 rows of 256 bytes
		for (int row = 0; row < 8; row++) begin
			select_osd();
			send_byte(8'h20 | 8'(row));
			repeat (256) send_byte(8'hff);
			release_osd();
		end
		wait_fall(1'b1, VS_LIMIT);
		count_frame(r_full, b_full, r_osd, g_tint, reads);
		compare_value(`OSD_WIDTH * `OSD_HEIGHT, g_tint);
		compare_value(`OSD_WIDTH * `OSD_HEIGHT, r_osd);
		// enable bit cleared
		select_osd();
		send_byte(8'h40);
		release_osd();
		count_frame(r_full, b_full, r_osd, g_tint, reads);
		compare_value(0, g_tint);
		end_test();
	endtask

	initial begin
		void'($urandom(21));
		ss = 1'b1;
		bus_cycle = '0;
		data = '0;
		reg_sel = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		reg_uds = 1'b1;
		reg_lds = 1'b1;
		reg_rw = 1'b1;
		sck = 1'b0;
		spi_sel = 1'b1;
		sdi = 1'b0;
		repeat (2) @(negedge clk);
		ss <= 1'b0;
		reset_values();
		register_access();
		sync_timing();
		address_stepping();
		pixel_output();
		osd_window();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+source
source/video_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/video_fetch.sv
source/osd_overlay.sv
source/video.sv
tb/video_tb.sv

// ==== Makefile ====
# Verilator build and run of the video controller testbench

TOP = video_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
